/* src/cu_arbiter_macros.svh */
////////////////////////////////////////////////////////////
// CU read arbiter constants
// Cluster size, field widths and burst buffer sizing
////////////////////////////////////////////////////////////

`ifndef CU_ARBITER_MACROS_SVH
`define CU_ARBITER_MACROS_SVH

// Cluster size, must equal 2**CU_ID_BITS
`define NUM_CU 4
`define CU_ID_BITS 2

// Field widths
`define ADDR_BITS 32
`define TAG_BITS 8
`define DATA_BITS 64

// Burst command buffer
`define CMD_BUFFER_DEPTH 8
`define CMD_ALFULL_MARGIN 2

`endif

/* src/cu_arbiter_pkg.sv */
////////////////////////////////////////////////////////////
// CU read arbiter types
// Command, response and data line layouts
////////////////////////////////////////////////////////////

`include "cu_arbiter_macros.svh"

package cu_arbiter_pkg;

	// Read command from a CU towards memory, 42 bits
	typedef struct packed {
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`ADDR_BITS-1:0]  address;
		logic [`TAG_BITS-1:0]   tag;
	} command_line_t;

	// Read response back to a CU, 10 bits
	typedef struct packed {
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`TAG_BITS-1:0]   tag;
	} response_line_t;

	// Read data line back to a CU, 74 bits
	typedef struct packed {
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`TAG_BITS-1:0]   tag;
		logic [`DATA_BITS-1:0]  data;
	} data_line_t;

endpackage

/* src/cmd_stream_if.sv */
////////////////////////////////////////////////////////////
// Command stream between arbiter and burst buffer
// Granted commands forward, fill state back
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface cmd_stream_if;

	// One push per cycle with valid high
	logic                          valid;
	cu_arbiter_pkg::command_line_t command;

	// Fill state of the buffer
	logic alfull;
	logic full;

	modport source (
		output valid,
		output command,
		input  alfull,
		input  full
	);

	modport sink (
		input  valid,
		input  command,
		output alfull,
		output full
	);

endinterface

/* src/rr_command_arbiter.sv */
////////////////////////////////////////////////////////////
// Round-robin read command arbiter
// Picks one CU command per cycle and registers it onto
// the command stream towards the burst buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module rr_command_arbiter (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  logic [`NUM_CU-1:0]            cu_cmd_valid,
	input  cu_arbiter_pkg::command_line_t cu_cmd [`NUM_CU],
	output logic [`NUM_CU-1:0]            cu_cmd_grant,
	cmd_stream_if.source                  stream
);

	localparam int PTR_BITS = `CU_ID_BITS;

	logic [PTR_BITS-1:0] priority_ptr;
	logic [PTR_BITS-1:0] winner;
	logic [PTR_BITS-1:0] idx;
	logic                found;
	logic                allow;

	////////////////////////////////////////////////////////////
	// Grant selection
	////////////////////////////////////////////////////////////

	// Buffer margin covers the one command in the stream register
	assign allow = enabled && !stream.alfull && !stream.full;

	always_comb begin
		found  = 1'b0;
		winner = priority_ptr;
		idx    = priority_ptr;
		// Search starts at the pointer, index wraps with NUM_CU a power of two
		for (int k = 0; k < `NUM_CU; k++) begin
			idx = priority_ptr + PTR_BITS'(k);
			if (allow && !found && cu_cmd_valid[idx]) begin
				found  = 1'b1;
				winner = idx;
			end
		end
	end

	always_comb begin
		cu_cmd_grant = '0;
		if (found) begin
			cu_cmd_grant[winner] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Stream register and priority update
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stream.valid <= 1'b0;
			priority_ptr <= '0;
		end else begin
			stream.valid <= found;
			// Next search begins just past the winner
			if (found) begin
				priority_ptr <= winner + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (found) begin
			stream.command <= cu_cmd[winner];
		end
	end

endmodule

/* src/burst_command_buffer.sv */
////////////////////////////////////////////////////////////
// Burst read command buffer
// FIFO of granted commands with almost-full margin and
// request/grant handshake towards the memory bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module burst_command_buffer (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enabled,
	input  logic                          bus_grant,
	output logic                          bus_request,
	output logic                          bus_cmd_valid,
	output cu_arbiter_pkg::command_line_t bus_cmd,
	cmd_stream_if.sink                    stream
);

	localparam int DEPTH         = `CMD_BUFFER_DEPTH;
	localparam int ALFULL_MARGIN = `CMD_ALFULL_MARGIN;
	localparam int PTR_BITS      = $clog2(DEPTH);
	localparam int CNT_BITS      = $clog2(DEPTH + 1);

	cu_arbiter_pkg::command_line_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;
	logic                push;
	logic                pop;
	logic                empty;

	////////////////////////////////////////////////////////////
	// Fill state
	////////////////////////////////////////////////////////////

	assign empty         = (count == '0);
	assign stream.full   = (count == CNT_BITS'(DEPTH));
	assign stream.alfull = (count >= CNT_BITS'(DEPTH - ALFULL_MARGIN));

	assign push = stream.valid;
	// Request may be held high while disabled, so never pop an empty buffer
	assign pop  = bus_request && bus_grant && !empty;

	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + 1'b1;
		end else if (!push && pop) begin
			count_next = count - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count_next;
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= stream.command;
		end
	end

	////////////////////////////////////////////////////////////
	// Memory bus side
	////////////////////////////////////////////////////////////

	// Request tracks occupancy after this edge, frozen while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			bus_request   <= 1'b0;
			bus_cmd_valid <= 1'b0;
		end else begin
			if (enabled) begin
				bus_request <= (count_next != '0);
			end
			bus_cmd_valid <= pop;
		end
	end

	// Popped head, shown for one cycle with bus_cmd_valid
	always_ff @(posedge clock) begin
		if (pop) begin
			bus_cmd <= mem[rd_ptr];
		end
	end

endmodule

/* src/cu_return_demux.sv */
////////////////////////////////////////////////////////////
// Return line demux
// Routes a returning line to the CU named by its cu_id
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module cu_return_demux #(
	parameter type line_t = cu_arbiter_pkg::response_line_t
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               in_valid,
	input  line_t              in_line,
	output logic [`NUM_CU-1:0] out_valid,
	output line_t              out_line
);

	// One valid bit per CU, at most one high
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid <= '0;
		end else begin
			for (int i = 0; i < `NUM_CU; i++) begin
				out_valid[i] <= in_valid && (in_line.cu_id == `CU_ID_BITS'(i));
			end
		end
	end

	// Shared payload seen by every CU
	always_ff @(posedge clock) begin
		if (in_valid) begin
			out_line <= in_line;
		end
	end

endmodule

/* src/cu_arbiter_control.sv */
////////////////////////////////////////////////////////////
// CU cluster read arbiter and control
// Merges CU read commands onto one memory bus and routes
// responses and data lines back by CU identifier
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module cu_arbiter_control (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  logic [`NUM_CU-1:0]             cu_cmd_valid,
	input  cu_arbiter_pkg::command_line_t  cu_cmd [`NUM_CU],
	output logic [`NUM_CU-1:0]             cu_cmd_grant,
	input  logic                           bus_grant,
	output logic                           bus_request,
	output logic                           bus_cmd_valid,
	output cu_arbiter_pkg::command_line_t  bus_cmd,
	input  logic                           resp_valid,
	input  cu_arbiter_pkg::response_line_t resp,
	output logic [`NUM_CU-1:0]             cu_resp_valid,
	output cu_arbiter_pkg::response_line_t cu_resp,
	input  logic                           data_valid,
	input  cu_arbiter_pkg::data_line_t     data,
	output logic [`NUM_CU-1:0]             cu_data_valid,
	output cu_arbiter_pkg::data_line_t     cu_data
);

	logic                           enabled;
	logic                           resp_latched_valid;
	cu_arbiter_pkg::response_line_t resp_latched;
	logic                           data_latched_valid;
	cu_arbiter_pkg::data_line_t     data_latched;

	cmd_stream_if cmd_stream ();

	////////////////////////////////////////////////////////////
	// Enable and return input registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled            <= 1'b0;
			resp_latched_valid <= 1'b0;
			data_latched_valid <= 1'b0;
		end else begin
			enabled            <= enabled_in;
			resp_latched_valid <= resp_valid;
			data_latched_valid <= data_valid;
		end
	end

	always_ff @(posedge clock) begin
		resp_latched <= resp;
		data_latched <= data;
	end

	////////////////////////////////////////////////////////////
	// Read command path
	////////////////////////////////////////////////////////////

	rr_command_arbiter cmd_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.cu_cmd_valid(cu_cmd_valid),
		.cu_cmd      (cu_cmd),
		.cu_cmd_grant(cu_cmd_grant),
		.stream      (cmd_stream.source)
	);

	burst_command_buffer cmd_buffer (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.bus_grant    (bus_grant),
		.bus_request  (bus_request),
		.bus_cmd_valid(bus_cmd_valid),
		.bus_cmd      (bus_cmd),
		.stream       (cmd_stream.sink)
	);

	////////////////////////////////////////////////////////////
	// Return paths
	////////////////////////////////////////////////////////////

	cu_return_demux #(
		.line_t(cu_arbiter_pkg::response_line_t)
	) resp_demux (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (resp_latched_valid),
		.in_line  (resp_latched),
		.out_valid(cu_resp_valid),
		.out_line (cu_resp)
	);

	cu_return_demux #(
		.line_t(cu_arbiter_pkg::data_line_t)
	) data_demux (
		.clock    (clock),
		.rstn     (rstn),
		.in_valid (data_latched_valid),
		.in_line  (data_latched),
		.out_valid(cu_data_valid),
		.out_line (cu_data)
	);

endmodule

/* verification/cu_arbiter_props.sv */
////////////////////////////////////////////////////////////
// Protocol properties of the CU read arbiter
// Grant shape, bus pop timing and enable gating
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module cu_arbiter_props (
	input logic               clock,
	input logic               rstn,
	input logic               enabled,
	input logic [`NUM_CU-1:0] cu_cmd_grant,
	input logic               bus_request,
	input logic               bus_grant,
	input logic               bus_cmd_valid
);

	// At most one CU granted per cycle
	grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cu_cmd_grant))
		else $error("more than one CU granted in one cycle");

	// Bus command only one cycle after request and grant
	cmd_after_pop: assert property (@(posedge clock) disable iff (!rstn)
		bus_cmd_valid |-> $past(bus_request && bus_grant))
		else $error("bus command without a sampled request and grant");

	// Registered enable gates all grants
	grant_needs_enable: assert property (@(posedge clock) disable iff (!rstn)
		!enabled |-> (cu_cmd_grant == '0))
		else $error("CU granted while disabled");

endmodule

/* verification/tb_cu_arbiter_control.sv */
////////////////////////////////////////////////////////////
// Testbench for the CU cluster read arbiter
// Directed tests of arbitration, back-pressure, enable
// and return routing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cu_arbiter_macros.svh"

module tb_cu_arbiter_control;

	localparam int RETURN_LINES    = 32;
	// Upper bound on commands over all command tests
	localparam int COMMAND_COUNT   = 6 * `NUM_CU;
	localparam int TOTAL_COMMANDS  = COMMAND_COUNT + 2 * RETURN_LINES;
	localparam int WATCHDOG_CYCLES = TOTAL_COMMANDS * 40 + 2000;

	logic                           clock;
	logic                           rstn;
	logic                           enabled_in;
	logic                           bus_grant;
	logic                           bus_request;
	logic                           bus_cmd_valid;
	logic                           resp_valid;
	logic                           data_valid;
	logic [`NUM_CU-1:0]             cu_cmd_valid;
	logic [`NUM_CU-1:0]             cu_cmd_grant;
	logic [`NUM_CU-1:0]             cu_resp_valid;
	logic [`NUM_CU-1:0]             cu_data_valid;
	cu_arbiter_pkg::command_line_t  cu_cmd [`NUM_CU];
	cu_arbiter_pkg::command_line_t  bus_cmd;
	cu_arbiter_pkg::response_line_t resp;
	cu_arbiter_pkg::response_line_t cu_resp;
	cu_arbiter_pkg::data_line_t     data;
	cu_arbiter_pkg::data_line_t     cu_data;

	// Reference state
	cu_arbiter_pkg::command_line_t expected_cmds [$];
	int                            grant_order [$];
	int                            rr_ptr;
	logic [31:0]                   rng_state = 32'he0ea;
	logic                          enable_model;
	logic                          pop_model;
	bit                            refill;

	cu_arbiter_control uut (.*);

	bind cu_arbiter_control cu_arbiter_props props (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.cu_cmd_grant (cu_cmd_grant),
		.bus_request  (bus_request),
		.bus_grant    (bus_grant),
		.bus_cmd_valid(bus_cmd_valid)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Registered enable and sampled request-and-grant
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_model <= 1'b0;
			pop_model    <= 1'b0;
		end else begin
			enable_model <= enabled_in;
			pop_model    <= bus_request && bus_grant;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired: the tests did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog timeout");
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic cu_arbiter_pkg::command_line_t random_command(input int cu);
		cu_arbiter_pkg::command_line_t c;
		logic [31:0]                   r;
		r         = next_random();
		c.cu_id   = `CU_ID_BITS'(cu);
		c.tag     = r[`TAG_BITS-1:0];
		c.address = next_random();
		return c;
	endfunction

	task automatic present_all();
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_cmd[i] = random_command(i);
		end
		cu_cmd_valid = '1;
	endtask

	task automatic check_idle();
		assert (cu_cmd_grant == '0 && !bus_request && !bus_cmd_valid
			&& cu_resp_valid == '0 && cu_data_valid == '0)
		else fail_now("outputs not idle around reset");
	endtask

	// One clock of the command path, checked at the falling edge
	task automatic run_cycle();
		int                            winner;
		int                            idx;
		cu_arbiter_pkg::command_line_t head;
		@(negedge clock);
		winner = -1;
		// First valid CU at or after the pointer
		for (int k = `NUM_CU - 1; k >= 0; k--) begin
			idx = (rr_ptr + k) % `NUM_CU;
			if (cu_cmd_valid[idx]) begin
				winner = idx;
			end
		end
		if (cu_cmd_grant != '0) begin
			assert (enable_model && winner >= 0 && cu_cmd_grant == (`NUM_CU'(1) << winner))
			else fail_now($sformatf("grant %b, expected CU %0d", cu_cmd_grant, winner));
			expected_cmds.push_back(cu_cmd[winner]);
			grant_order.push_back(winner);
			rr_ptr = (winner + 1) % `NUM_CU;
		end else begin
			winner = -1;
		end
		if (bus_cmd_valid) begin
			assert (pop_model && expected_cmds.size() > 0)
			else fail_now("bus command without request, grant or pending command");
			head = expected_cmds.pop_front();
			assert (bus_cmd == head)
			else fail_now($sformatf("bus command %h, expected %h", bus_cmd, head));
		end
		@(posedge clock);
		#1;
		if (winner >= 0 && refill) begin
			cu_cmd[winner] = random_command(winner);
		end else if (winner >= 0) begin
			cu_cmd_valid[winner] = 1'b0;
		end
	endtask

	task automatic drain(input int limit);
		int cycles;
		cycles = 0;
		while (cu_cmd_valid != '0 || expected_cmds.size() > 0) begin
			assert (cycles < limit) else fail_now("command path did not drain in time");
			run_cycle();
			cycles++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		rstn = 1'b0;
		repeat (10) begin
			@(negedge clock);
			check_idle();
		end
		@(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		check_idle();
		@(posedge clock);
		#1;
	endtask

	task automatic test_round_robin();
		bus_grant = 1'b1;
		for (int batch = 0; batch < 2; batch++) begin
			grant_order.delete();
			present_all();
			drain(100);
			for (int i = 0; i < `NUM_CU; i++) begin
				assert (grant_order.size() == `NUM_CU && grant_order[i] == i)
				else fail_now($sformatf("batch %0d slot %0d not granted to CU %0d", batch, i, i));
			end
		end
	endtask

	task automatic test_back_pressure();
		int idle;
		int accepted;
		bus_grant = 1'b0;
		refill    = 1'b1;
		idle      = 0;
		present_all();
		// Grants stop for good once almost-full is reached
		for (int c = 0; idle < 4; c++) begin
			assert (c < 60) else fail_now("grants did not stop under back-pressure");
			accepted = expected_cmds.size();
			run_cycle();
			idle = (expected_cmds.size() == accepted) ? idle + 1 : 0;
		end
		accepted = expected_cmds.size();
		assert (accepted >= `CMD_BUFFER_DEPTH - `CMD_ALFULL_MARGIN
			&& accepted <= `CMD_BUFFER_DEPTH)
		else fail_now($sformatf("%0d commands accepted while stalled", accepted));
		assert (bus_request) else fail_now("bus_request low with commands buffered");
		refill    = 1'b0;
		bus_grant = 1'b1;
		drain(200);
	endtask

	task automatic test_enable();
		grant_order.delete();
		enabled_in = 1'b0;
		repeat (2) run_cycle();
		present_all();
		repeat (6) run_cycle();
		assert (grant_order.size() == 0 && cu_cmd_valid == '1)
		else fail_now("CU served while disabled");
		enabled_in = 1'b1;
		drain(100);
	endtask

	// Routing check two cycles after each sent line
	task automatic test_return(input bit use_data);
		cu_arbiter_pkg::data_line_t line;
		cu_arbiter_pkg::data_line_t sent [$];
		logic [`NUM_CU-1:0]         exp_valid;
		logic [31:0]                r;
		for (int j = 0; j < RETURN_LINES + 2; j++) begin
			r          = next_random();
			line.cu_id = r[`CU_ID_BITS-1:0];
			line.tag   = r[15:8];
			line.data  = {next_random(), next_random()};
			sent.push_back(line);
			resp_valid = !use_data && j < RETURN_LINES;
			resp.cu_id = line.cu_id;
			resp.tag   = line.tag;
			data_valid = use_data && j < RETURN_LINES;
			data       = line;
			@(negedge clock);
			if (j >= 2) begin
				line      = sent[j - 2];
				exp_valid = `NUM_CU'(1) << line.cu_id;
				assert ((use_data ? cu_data_valid : cu_resp_valid) == exp_valid
					&& (use_data ? cu_resp_valid : cu_data_valid) == '0)
				else fail_now($sformatf("line %0d valid bits wrong for CU %0d", j - 2, line.cu_id));
				assert (use_data ? cu_data == line
					: (cu_resp.cu_id == line.cu_id && cu_resp.tag == line.tag))
				else fail_now($sformatf("line %0d payload differs from the sent line", j - 2));
			end
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		rstn         = 1'b0;
		enabled_in   = 1'b1;
		bus_grant    = 1'b0;
		cu_cmd_valid = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			cu_cmd[i] = '0;
		end
		resp_valid = 1'b0;
		resp       = '0;
		data_valid = 1'b0;
		data       = '0;
		refill     = 1'b0;
		rr_ptr     = 0;
		test_reset();
		test_round_robin();
		test_back_pressure();
		test_enable();
		test_return(1'b0);
		test_return(1'b1);
		$display("TB PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+src
src/cu_arbiter_pkg.sv
src/cmd_stream_if.sv
src/rr_command_arbiter.sv
src/burst_command_buffer.sv
src/cu_return_demux.sv
src/cu_arbiter_control.sv
verification/cu_arbiter_props.sv
verification/tb_cu_arbiter_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CU arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_cu_arbiter_control
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
